/* source/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Address and data widths
`define ADDR_W 16
`define WORD_W 16

// Address split into tag, set index and byte offset
`define TAG_W 5
`define INDEX_W 8
`define OFFSET_W 3

// Line geometry
`define LINE_WORDS 4

// Cycles from a memory read request to its data
`define MEM_LATENCY 2

`endif

/* source/cache_pkg.sv */
`include "cache_macros.svh"

package cache_pkg;

    typedef logic [`WORD_W-1:0]  word_t;
    typedef logic [`TAG_W-1:0]   tag_t;
    typedef logic [`INDEX_W-1:0] index_t;

    // Write-back and fill states must stay consecutive
    typedef enum logic [3:0] {
        idle,
        compare_read,
        compare_write,
        writeback_0,
        writeback_1,
        writeback_2,
        writeback_3,
        fill_0,
        fill_1,
        fill_2,
        fill_3,
        fill_4,
        fill_5
    } ctrl_state_e;

endpackage

/* source/cache_way.sv */
`timescale 1ns/10ps
`include "cache_macros.svh"

module cache_way (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 enable,
    input  logic                 comp,
    input  logic                 write,
    input  logic                 valid_in,
    input  cache_pkg::index_t    index,
    input  logic [`OFFSET_W-1:0] offset,
    input  cache_pkg::tag_t      tag_in,
    input  cache_pkg::word_t     data_in,
    output logic                 hit,
    output logic                 valid,
    output logic                 dirty,
    output cache_pkg::tag_t      tag_out,
    output cache_pkg::word_t     data_out
);

    import cache_pkg::*;

    localparam int SETS = 1 << `INDEX_W;

    tag_t                   tag_mem [SETS];
    word_t                  data_mem [SETS][`LINE_WORDS];
    logic [SETS-1:0]        valid_bits;
    logic [SETS-1:0]        dirty_bits;
    logic [`OFFSET_W-2:0]   word_sel;
    logic                   tag_match;
    logic                   way_write;

    // Byte bit 0 is dropped
    assign word_sel  = offset[`OFFSET_W-1:1];
    assign tag_match = (tag_mem[index] == tag_in);
    assign way_write = enable && write;

    // Lookup is purely combinational
    assign valid    = valid_bits[index];
    assign dirty    = dirty_bits[index];
    assign tag_out  = tag_mem[index];
    assign data_out = data_mem[index][word_sel];
    assign hit      = enable && comp && valid && tag_match;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (way_write) begin
            if (comp) begin
                // Compare write only lands on a hit
                if (hit) begin
                    dirty_bits[index] <= 1'b1;
                end
            end else begin
                valid_bits[index] <= valid_in;
                dirty_bits[index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (way_write && (!comp || hit)) begin
            data_mem[index][word_sel] <= data_in;
            if (!comp) begin
                tag_mem[index] <= tag_in;
            end
        end
    end

endmodule

/* source/main_memory.sv */
`timescale 1ns/10ps
`include "cache_macros.svh"

module main_memory (
    input  logic               clk,
    input  logic               rst,
    input  logic               rd,
    input  logic               wr,
    input  logic [`ADDR_W-1:0] addr,
    input  cache_pkg::word_t   data_in,
    output cache_pkg::word_t   data_out
);

    import cache_pkg::*;

    localparam int BANKS      = `LINE_WORDS;
    localparam int ROW_W      = `ADDR_W - `OFFSET_W;
    localparam int BANK_DEPTH = 1 << ROW_W;

    logic [`MEM_LATENCY-1:0] rd_pipe;
    logic [`ADDR_W-1:0]      addr_pipe [`MEM_LATENCY];
    logic [1:0]              wr_bank;
    logic [ROW_W-1:0]        wr_row;
    logic [1:0]              rd_bank;
    logic [ROW_W-1:0]        rd_row;
    word_t                   bank_rd_data [BANKS];

    // Bank from address bits 2:1, row from the rest
    assign wr_bank = addr[`OFFSET_W-1:1];
    assign wr_row  = addr[`ADDR_W-1:`OFFSET_W];

    // Read pipeline, one stage per cycle of latency
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pipe <= '0;
        end else begin
            rd_pipe <= {rd_pipe[`MEM_LATENCY-2:0], rd};
        end
    end

    always_ff @(posedge clk) begin
        addr_pipe[0] <= addr;
        for (int i = 1; i < `MEM_LATENCY; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
    end

    assign rd_bank = addr_pipe[`MEM_LATENCY-1][`OFFSET_W-1:1];
    assign rd_row  = addr_pipe[`MEM_LATENCY-1][`ADDR_W-1:`OFFSET_W];

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        word_t cells [BANK_DEPTH] = '{default: '0};
        logic  bank_we;

        assign bank_we = wr && (wr_bank == 2'(b));

        always_ff @(posedge clk) begin
            if (bank_we) begin
                cells[wr_row] <= data_in;
            end
        end

        assign bank_rd_data[b] = cells[rd_row];
    end

    // Word shows up exactly MEM_LATENCY cycles after its request
    assign data_out = rd_pipe[`MEM_LATENCY-1] ? bank_rd_data[rd_bank] : '0;

endmodule

/* source/cache_control.sv */
`timescale 1ns/10ps
`include "cache_macros.svh"

module cache_control (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rd,
    input  logic                 wr,
    input  logic [`ADDR_W-1:0]   addr,
    input  cache_pkg::word_t     data_in,
    input  logic                 hit_0,
    input  logic                 hit_1,
    input  logic                 valid_0,
    input  logic                 valid_1,
    input  logic                 dirty_0,
    input  logic                 dirty_1,
    input  cache_pkg::tag_t      tag_out_0,
    input  cache_pkg::tag_t      tag_out_1,
    input  cache_pkg::word_t     data_out_0,
    input  cache_pkg::word_t     data_out_1,
    input  cache_pkg::word_t     mem_data_out,
    output logic                 enable_0,
    output logic                 enable_1,
    output logic                 comp,
    output logic                 write,
    output logic                 valid_in,
    output cache_pkg::index_t    index,
    output logic [`OFFSET_W-1:0] offset,
    output cache_pkg::tag_t      tag_in,
    output cache_pkg::word_t     way_data_in,
    output logic                 mem_rd,
    output logic                 mem_wr,
    output logic [`ADDR_W-1:0]   mem_addr,
    output cache_pkg::word_t     mem_data_in,
    output cache_pkg::word_t     data_out,
    output logic                 done,
    output logic                 stall,
    output logic                 cache_hit
);

    import cache_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e next_state;
    logic        victim_q;
    logic        way_q;
    logic        evict_q;
    word_t       read_q;

    tag_t        req_tag;
    index_t      req_index;
    logic [1:0]  req_word;
    logic        hit_any;
    logic        in_compare;
    logic        miss_way;
    logic        miss_dirty;
    tag_t        victim_tag;
    word_t       victim_data;
    logic [1:0]  wb_beat;
    logic [1:0]  rd_beat;
    logic [1:0]  wr_beat;
    logic        capture;

    assign req_tag   = addr[`ADDR_W-1 -: `TAG_W];
    assign req_index = addr[`OFFSET_W +: `INDEX_W];
    assign req_word  = addr[`OFFSET_W-1:1];

    assign hit_any    = hit_0 | hit_1;
    assign in_compare = (state_q == compare_read) || (state_q == compare_write);

    // First invalid way wins, else the victim flag decides
    assign miss_way   = !valid_0 ? 1'b0 : (!valid_1 ? 1'b1 : victim_q);
    assign miss_dirty = miss_way ? (valid_1 & dirty_1) : (valid_0 & dirty_0);

    assign victim_tag  = way_q ? tag_out_1 : tag_out_0;
    assign victim_data = way_q ? data_out_1 : data_out_0;

    // Beat within each burst
    assign wb_beat = 2'(state_q - writeback_0);
    assign rd_beat = 2'(state_q - fill_0);
    assign wr_beat = 2'(state_q - fill_2);

    // Requested word of a read miss arrives before fill_5
    assign capture = rd && (state_q >= fill_2) && (state_q <= fill_4) && (req_word == wr_beat);

    always_comb begin
        next_state  = state_q;
        enable_0    = 1'b0;
        enable_1    = 1'b0;
        comp        = 1'b0;
        write       = 1'b0;
        valid_in    = 1'b0;
        index       = req_index;
        offset      = addr[`OFFSET_W-1:0];
        tag_in      = req_tag;
        way_data_in = data_in;
        mem_rd      = 1'b0;
        mem_wr      = 1'b0;
        mem_addr    = {addr[`ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
        mem_data_in = victim_data;
        data_out    = read_q;
        done        = 1'b0;
        stall       = 1'b1;
        cache_hit   = 1'b0;

        case (state_q)
            idle: begin
                stall = 1'b0;
                if (rd) begin
                    next_state = compare_read;
                end else if (wr) begin
                    next_state = compare_write;
                end
            end
            compare_read, compare_write: begin
                // Both ways look up in parallel
                enable_0  = 1'b1;
                enable_1  = 1'b1;
                comp      = 1'b1;
                write     = (state_q == compare_write);
                done      = hit_any;
                cache_hit = hit_any;
                data_out  = hit_1 ? data_out_1 : data_out_0;
                if (hit_any) begin
                    next_state = idle;
                end else if (miss_dirty) begin
                    next_state = writeback_0;
                end else begin
                    next_state = fill_0;
                end
            end
            writeback_0, writeback_1, writeback_2, writeback_3: begin
                enable_0    = !way_q;
                enable_1    = way_q;
                offset      = {wb_beat, 1'b0};
                mem_wr      = 1'b1;
                mem_addr    = {victim_tag, req_index, wb_beat, 1'b0};
                mem_data_in = victim_data;
                next_state  = ctrl_state_e'(state_q + 1);
            end
            fill_0, fill_1, fill_2, fill_3, fill_4, fill_5: begin
                enable_0 = !way_q;
                enable_1 = way_q;
                if (state_q <= fill_3) begin
                    mem_rd   = 1'b1;
                    mem_addr = {addr[`ADDR_W-1:`OFFSET_W], rd_beat, 1'b0};
                end
                if (state_q >= fill_2) begin
                    write       = 1'b1;
                    valid_in    = 1'b1;
                    offset      = {wr_beat, 1'b0};
                    way_data_in = (wr && (req_word == wr_beat)) ? data_in : mem_data_out;
                end
                if (state_q == fill_5) begin
                    // Last word of a write miss marks the line dirty
                    comp       = wr;
                    done       = 1'b1;
                    data_out   = (req_word == 2'd3) ? mem_data_out : read_q;
                    next_state = idle;
                end else begin
                    next_state = ctrl_state_e'(state_q + 1);
                end
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= idle;
            victim_q <= 1'b0;
            way_q    <= 1'b0;
            evict_q  <= 1'b0;
        end else begin
            state_q <= next_state;
            if (in_compare && !hit_any) begin
                way_q   <= miss_way;
                evict_q <= valid_0 & valid_1;
            end
            if ((state_q == fill_5) && evict_q) begin
                victim_q <= ~victim_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            read_q <= mem_data_out;
        end
    end

endmodule

/* source/mem_system.sv */
`timescale 1ns/10ps
`include "cache_macros.svh"

module mem_system (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rd,
    input  logic                 wr,
    input  logic [`ADDR_W-1:0]   addr,
    input  cache_pkg::word_t     data_in,
    output cache_pkg::word_t     data_out,
    output logic                 done,
    output logic                 stall,
    output logic                 cache_hit
);

    import cache_pkg::*;

    // Shared way request
    logic                 enable_0;
    logic                 enable_1;
    logic                 comp;
    logic                 write;
    logic                 valid_in;
    index_t               index;
    logic [`OFFSET_W-1:0] offset;
    tag_t                 tag_in;
    word_t                way_data_in;

    // Per-way results
    logic                 hit_0;
    logic                 hit_1;
    logic                 valid_0;
    logic                 valid_1;
    logic                 dirty_0;
    logic                 dirty_1;
    tag_t                 tag_out_0;
    tag_t                 tag_out_1;
    word_t                way_data_out_0;
    word_t                way_data_out_1;

    // Memory side
    logic                 mem_rd;
    logic                 mem_wr;
    logic [`ADDR_W-1:0]   mem_addr;
    word_t                mem_data_in;
    word_t                mem_data_out;

    cache_way way_0_i (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable_0),
        .comp     (comp),
        .write    (write),
        .valid_in (valid_in),
        .index    (index),
        .offset   (offset),
        .tag_in   (tag_in),
        .data_in  (way_data_in),
        .hit      (hit_0),
        .valid    (valid_0),
        .dirty    (dirty_0),
        .tag_out  (tag_out_0),
        .data_out (way_data_out_0)
    );

    cache_way way_1_i (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable_1),
        .comp     (comp),
        .write    (write),
        .valid_in (valid_in),
        .index    (index),
        .offset   (offset),
        .tag_in   (tag_in),
        .data_in  (way_data_in),
        .hit      (hit_1),
        .valid    (valid_1),
        .dirty    (dirty_1),
        .tag_out  (tag_out_1),
        .data_out (way_data_out_1)
    );

    cache_control ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .rd           (rd),
        .wr           (wr),
        .addr         (addr),
        .data_in      (data_in),
        .hit_0        (hit_0),
        .hit_1        (hit_1),
        .valid_0      (valid_0),
        .valid_1      (valid_1),
        .dirty_0      (dirty_0),
        .dirty_1      (dirty_1),
        .tag_out_0    (tag_out_0),
        .tag_out_1    (tag_out_1),
        .data_out_0   (way_data_out_0),
        .data_out_1   (way_data_out_1),
        .mem_data_out (mem_data_out),
        .enable_0     (enable_0),
        .enable_1     (enable_1),
        .comp         (comp),
        .write        (write),
        .valid_in     (valid_in),
        .index        (index),
        .offset       (offset),
        .tag_in       (tag_in),
        .way_data_in  (way_data_in),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr),
        .mem_addr     (mem_addr),
        .mem_data_in  (mem_data_in),
        .data_out     (data_out),
        .done         (done),
        .stall        (stall),
        .cache_hit    (cache_hit)
    );

    main_memory mem_i (
        .clk      (clk),
        .rst      (rst),
        .rd       (mem_rd),
        .wr       (mem_wr),
        .addr     (mem_addr),
        .data_in  (mem_data_in),
        .data_out (mem_data_out)
    );

endmodule

/* testbench/mem_system_tb.sv */
`timescale 1ns/10ps
`include "cache_macros.svh"

module mem_system_tb;

    typedef struct packed {
        logic [3:0]         lat;
        logic               hit;
        logic [`WORD_W-1:0] word;
    } expect_t;

    logic               clk;
    logic               rst;
    logic               rd;
    logic               wr;
    logic [`ADDR_W-1:0] addr;
    logic [`WORD_W-1:0] data_in;
    logic [`WORD_W-1:0] data_out;
    logic               done;
    logic               stall;
    logic               cache_hit;

    // Shadow of the program-visible memory and of the two ways
    logic [`WORD_W-1:0] shadow [32768];
    logic [4:0]         m_tag [2][256];
    logic               m_valid [2][256];
    logic               m_dirty [2][256];
    logic               m_victim;

    logic [31:0] lcg_state;
    expect_t     exp_rsp;
    logic        exp_write;
    string       cur_name;
    int          issued_count;
    int          answered_count;
    int          wait_cycles;
    logic        reset_checked;
    int          errors;
    int          checks;
    int          err_at_start;
    int          tests_run;
    int          tests_failed;
    string       test_name;

    mem_system dut_i (
        .clk       (clk),
        .rst       (rst),
        .rd        (rd),
        .wr        (wr),
        .addr      (addr),
        .data_in   (data_in),
        .data_out  (data_out),
        .done      (done),
        .stall     (stall),
        .cache_hit (cache_hit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected word, hit flag and latency, following the victim rule
    function automatic expect_t model_access(input logic is_write, input logic [15:0] a,
                                             input logic [15:0] d);
        expect_t    r;
        logic [4:0] tag;
        logic [7:0] idx;
        logic       way;
        logic       found;
        tag   = a[15:11];
        idx   = a[10:3];
        found = 1'b0;
        way   = 1'b0;
        if (m_valid[0][idx] && m_tag[0][idx] == tag) begin
            found = 1'b1;
        end else if (m_valid[1][idx] && m_tag[1][idx] == tag) begin
            found = 1'b1;
            way   = 1'b1;
        end
        if (found) begin
            r.lat = 4'd1;
        end else begin
            if (!m_valid[0][idx]) begin
                way = 1'b0;
            end else if (!m_valid[1][idx]) begin
                way = 1'b1;
            end else begin
                way = m_victim;
            end
            r.lat = (m_valid[way][idx] && m_dirty[way][idx]) ? 4'd11 : 4'd7;
            if (m_valid[0][idx] && m_valid[1][idx]) begin
                m_victim = !m_victim;
            end
            m_tag[way][idx]   = tag;
            m_valid[way][idx] = 1'b1;
            m_dirty[way][idx] = 1'b0;
        end
        if (is_write) begin
            m_dirty[way][idx] = 1'b1;
            shadow[a[15:1]]   = d;
        end
        r.hit  = found;
        r.word = shadow[a[15:1]];
        return r;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks = checks + 1;
        if (expected !== actual) begin
            $display("[ERROR] %s: %s expected %0h, actual %0h",
                     test_name, what, expected, actual);
            errors = errors + 1;
        end
    endtask

    // Compares every response against the model
    always @(negedge clk) begin
        if (!rst) begin
            if (!reset_checked) begin
                check_value("after reset stall", 32'd0, 32'(stall));
                check_value("after reset done", 32'd0, 32'(done));
                reset_checked = 1'b1;
            end else if (issued_count != answered_count) begin
                wait_cycles = wait_cycles + 1;
                if (wait_cycles == 1) begin
                    check_value({cur_name, " stall in idle"}, 32'd0, 32'(stall));
                end else begin
                    check_value({cur_name, " stall while busy"}, 32'd1, 32'(stall));
                end
                if (done) begin
                    check_value({cur_name, " hit"}, 32'(exp_rsp.hit), 32'(cache_hit));
                    check_value({cur_name, " latency"}, 32'(exp_rsp.lat), 32'(wait_cycles - 1));
                    if (!exp_write) begin
                        check_value({cur_name, " data"}, 32'(exp_rsp.word), 32'(data_out));
                    end
                    wait_cycles    = 0;
                    answered_count = answered_count + 1;
                end
            end else if (done) begin
                $display("done was raised with no request outstanding");
                errors = errors + 1;
            end
        end
    end

    task automatic issue_request(input string name, input logic is_write,
                                 input logic [15:0] a, input logic [15:0] d);
        int waited;
        waited = 0;
        @(posedge clk);
        exp_rsp      = model_access(is_write, a, d);
        exp_write    = is_write;
        cur_name     = name;
        issued_count = issued_count + 1;
        rd      <= !is_write;
        wr      <= is_write;
        addr    <= a;
        data_in <= d;
        while (answered_count != issued_count && waited < 50) begin
            @(posedge clk);
            waited = waited + 1;
        end
        if (answered_count != issued_count) begin
            $display("Timeout: %s saw no done within 50 cycles", name);
            $display("Result: FAILED");
            $finish;
        end else begin
            rd <= 1'b0;
            wr <= 1'b0;
        end
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        err_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run = tests_run + 1;
        if (errors == err_at_start) begin
            $display("test %s ok", test_name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s failed with %0d errors", test_name, errors - err_at_start);
        end
    endtask

    initial begin
        int                 n;
        logic [`ADDR_W-1:0] r_addr;
        logic [`WORD_W-1:0] r_data;
        logic               r_write;
        shadow         = '{default: '0};
        m_tag          = '{default: '0};
        m_valid        = '{default: '0};
        m_dirty        = '{default: '0};
        m_victim       = 1'b0;
        lcg_state      = 32'h6621f36b;
        issued_count   = 0;
        answered_count = 0;
        wait_cycles    = 0;
        reset_checked  = 1'b0;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        exp_write      = 1'b0;
        exp_rsp        = '0;
        rst     <= 1'b1;
        rd      <= 1'b0;
        wr      <= 1'b0;
        addr    <= '0;
        data_in <= '0;
        start_test("reset_first_miss");
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        issue_request("first read", 1'b0, 16'h1234, 16'h0000);
        finish_test();

        start_test("write_then_read_hit");
        issue_request("hit write", 1'b1, 16'h1234, 16'hbeef);
        issue_request("hit read", 1'b0, 16'h1234, 16'h0000);
        finish_test();

        // Line on set 0x42 goes to memory through a write-back, then comes back
        start_test("line_fill_neighbors");
        issue_request("seed word 0", 1'b1, 16'h2a10, 16'h5a10);
        issue_request("seed word 1", 1'b1, 16'h2a12, 16'h5a12);
        issue_request("seed word 2", 1'b1, 16'h2a14, 16'h5a14);
        issue_request("seed word 3", 1'b1, 16'h2a16, 16'h5a16);
        issue_request("conflict tag 6", 1'b0, 16'h3210, 16'h0000);
        issue_request("conflict tag 7", 1'b0, 16'h3a10, 16'h0000);
        issue_request("fill word 1", 1'b0, 16'h2a12, 16'h0000);
        issue_request("fill word 0", 1'b0, 16'h2a10, 16'h0000);
        issue_request("fill word 2", 1'b0, 16'h2a14, 16'h0000);
        issue_request("fill word 3", 1'b0, 16'h2a16, 16'h0000);
        finish_test();

        // Three tags on set 0x20
        start_test("eviction_writeback");
        issue_request("write tag 1", 1'b1, 16'h0902, 16'h1111);
        issue_request("write tag 2", 1'b1, 16'h1102, 16'h2222);
        issue_request("write tag 3", 1'b1, 16'h1902, 16'h3333);
        issue_request("reread tag 1", 1'b0, 16'h0902, 16'h0000);
        issue_request("reread tag 2", 1'b0, 16'h1102, 16'h0000);
        finish_test();

        // Four tags over two sets keep both ways thrashing
        start_test("random_conflicts");
        for (n = 0; n < 300; n++) begin
            lcg_state = lcg_next(lcg_state);
            r_addr    = {lcg_state[31:30], 3'b101, 7'b0110000, lcg_state[29],
                         lcg_state[28:27], 1'b0};
            r_write   = lcg_state[26];
            lcg_state = lcg_next(lcg_state);
            r_data    = lcg_state[31:16];
            issue_request($sformatf("random %0d", n), r_write, r_addr, r_data);
        end
        finish_test();

        repeat (2) @(posedge clk);
        $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+source
source/cache_pkg.sv
source/cache_way.sv
source/main_memory.sv
source/cache_control.sv
source/mem_system.sv
testbench/mem_system_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module mem_system_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vmem_system_tb)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
